// ==== include/sdr_config.svh ====
// build-time constants for the SDR control block
// identity codes show up in the status word read by firmware
// the overflow window must be at least 4 samples (2 bits) for the 1/4 threshold
// counter width is assumed to be 32 by the byte-lane read mux
`ifndef SDR_CONFIG_SVH
`define SDR_CONFIG_SVH

// fpga identity, 4 bits each
`define SDR_FPGA_ID       4'd3
`define SDR_FPGA_VER      4'd1

// log2 of the adc overflow window, 64 samples
`define SDR_OVFL_WIN_BITS 6

// cpu cycle counter width
`define SDR_CTR_WIDTH     32

`endif

// ==== hw/sdr_bus_pkg.sv ====
// word types and opcode bit positions of the stack CPU register bus
// the opcode is one-hot per register, so a single op may select several
// bit positions below must stay within the 16-bit opcode word
package sdr_bus_pkg;

    ////////////////////////////////////////
    // bus word types
    ////////////////////////////////////////

    // opcode word, one bit per register or event
    typedef logic [15:0] op_t;

    // top-of-stack word written by the cpu
    typedef logic [31:0] bus_word_t;

    // parallel-port read word returned to the cpu
    typedef logic [15:0] par_t;

    ////////////////////////////////////////
    // opcode bit positions
    ////////////////////////////////////////

    // register write target
    localparam int unsigned OP_SET_CTRL     = 0;

    // register read selects
    localparam int unsigned OP_GET_STATUS   = 1;
    localparam int unsigned OP_GET_SRQ      = 2;
    localparam int unsigned OP_GET_CPU_CTR0 = 3;
    localparam int unsigned OP_GET_CPU_CTR1 = 4;
    localparam int unsigned OP_GET_CPU_CTR2 = 5;
    localparam int unsigned OP_GET_CPU_CTR3 = 6;

    // events, taken with wr_evt
    localparam int unsigned OP_CPU_CTR_CLR  = 7;
    localparam int unsigned OP_CPU_CTR_ENA  = 8;
    localparam int unsigned OP_CPU_CTR_DIS  = 9;

endpackage

// ==== hw/sdr_status_pkg.sv ====
// layouts of the global control register and the status word
// both are 16 bits and are declared msb first
// spare control bits are stored but never read back
package sdr_status_pkg;

    ////////////////////////////////////////
    // global control register
    ////////////////////////////////////////

    typedef struct packed {
        logic [12:0] spare;      // bits 15..3, kept for firmware
        logic        interrupt;  // bit 2, host interrupt pin
        logic        eeprom_wp;  // bit 1, eeprom write protect
        logic        osc_en;     // bit 0, oscillator enable
    } ctrl_t;

    ////////////////////////////////////////
    // status word
    ////////////////////////////////////////

    typedef struct packed {
        logic       rx_overflow;  // bit 15, sticky adc overflow
        logic [2:0] rsvd;         // bits 14..12, read as zero
        logic [3:0] fpga_ver;     // bits 11..8
        logic [3:0] user;         // bits 7..4, bit 4 is gated counter enable
        logic [3:0] fpga_id;      // bits 3..0
    } status_t;

endpackage

// ==== hw/reg_bus_if.sv ====
// register bus of the stack CPU, no handshake
// op and tos are held by the cpu while exactly one strobe pulses
`timescale 1ns/100ps

interface reg_bus_if;
    import sdr_bus_pkg::*;

    op_t       op;      // one-hot register select
    bus_word_t tos;     // top-of-stack write data
    logic      rd_reg;  // register read strobe
    logic      wr_reg;  // register write strobe
    logic      wr_evt;  // event write strobe

    // driven from the top-level pins
    modport master (output op, tos, rd_reg, wr_reg, wr_evt);

    // register blocks only listen
    modport slave (input op, tos, rd_reg, wr_reg, wr_evt);

endinterface

// ==== hw/ctrl_regs.sv ====
// global control register and the two cpu cycle counters
// writes and events take effect at the next cpu_clk edge
// counters wrap silently at 2^SDR_CTR_WIDTH
// if ENA and DIS arrive together, disable wins
`timescale 1ns/100ps
`include "sdr_config.svh"

module ctrl_regs (
    input  logic                      cpu_clk,
    input  logic                      rx_ovfl_rst,
    reg_bus_if.slave                  bus,
    output sdr_status_pkg::ctrl_t     ctrl,
    output logic [`SDR_CTR_WIDTH-1:0] cpu_ctr0,
    output logic [`SDR_CTR_WIDTH-1:0] cpu_ctr1,
    output logic                      ctr_ena
);
    import sdr_bus_pkg::*;
    import sdr_status_pkg::*;

    localparam int CW = `SDR_CTR_WIDTH;

    // decoded bus strobes
    logic ctrl_wr;
    logic ctr_clr;
    logic ctr_on;
    logic ctr_off;

    assign ctrl_wr = bus.wr_reg && bus.op[OP_SET_CTRL];
    assign ctr_clr = bus.wr_evt && bus.op[OP_CPU_CTR_CLR];
    assign ctr_on  = bus.wr_evt && bus.op[OP_CPU_CTR_ENA];
    assign ctr_off = bus.wr_evt && bus.op[OP_CPU_CTR_DIS];

    ////////////////////////////////////////
    // control register
    ////////////////////////////////////////

    // low half of tos only, upper half is ignored
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
            ctrl <= '0;
        else if (ctrl_wr)
            ctrl <= ctrl_t'(bus.tos[15:0]);
    end

    ////////////////////////////////////////
    // cycle counters
    ////////////////////////////////////////

    // ctr0 counts every cycle, ctr1 only while enabled
    // firmware divides ctr1 by ctr0 to get a duty figure for a code section
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            cpu_ctr0 <= '0;
            cpu_ctr1 <= '0;
            ctr_ena  <= 1'b0;
        end
        else
        begin
            if (ctr_clr)
            begin
                cpu_ctr0 <= '0;
                cpu_ctr1 <= '0;
            end
            else
            begin
                cpu_ctr0 <= cpu_ctr0 + 1'b1;
                cpu_ctr1 <= cpu_ctr1 + {{(CW-1){1'b0}}, ctr_ena};
            end
            // later assignment gives disable priority
            if (ctr_on)
                ctr_ena <= 1'b1;
            if (ctr_off)
                ctr_ena <= 1'b0;
        end
    end

endmodule

// ==== hw/adc_ovfl_detect.sv ====
// windowed adc overflow detector with a sticky latch
// a window is 2^SDR_OVFL_WIN_BITS valid samples, gaps in adc_valid are skipped
// a window is flagged when at least a quarter of its samples carry overflow
// reset reloads the latch from the pulse instead of clearing it
`timescale 1ns/100ps
`include "sdr_config.svh"

module adc_ovfl_detect (
    input  logic cpu_clk,
    input  logic rx_ovfl_rst,
    input  logic adc_valid,
    input  logic adc_ovfl,
    output logic ovfl_pulse,
    output logic rx_overflow
);
    localparam int W = `SDR_OVFL_WIN_BITS;

    // quarter of the window, 2^(W-2)
    localparam logic [W:0] OVF_THRESH = {2'b00, 1'b1, {(W-2){1'b0}}};

    logic [W-1:0] smp_ctr;   // valid samples seen in this window
    logic [W:0]   ovf_cnt;   // overflow samples, one extra bit for a full window
    logic [W:0]   ovf_next;  // count including the current sample
    logic         win_end;

    assign ovf_next = ovf_cnt + {{W{1'b0}}, adc_ovfl};
    assign win_end  = adc_valid && (&smp_ctr);

    ////////////////////////////////////////
    // window counters
    ////////////////////////////////////////

    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            smp_ctr    <= '0;
            ovf_cnt    <= '0;
            ovfl_pulse <= 1'b0;
        end
        else
        begin
            // pulse lasts exactly one cycle
            ovfl_pulse <= 1'b0;
            if (adc_valid)
            begin
                // smp_ctr wraps back to zero on the last sample
                smp_ctr <= smp_ctr + 1'b1;
                if (win_end)
                begin
                    ovfl_pulse <= (ovf_next >= OVF_THRESH);
                    ovf_cnt    <= '0;
                end
                else
                    ovf_cnt <= ovf_next;
            end
        end
    end

    // sticky latch, rises one edge after the pulse
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
            rx_overflow <= ovfl_pulse;
        else
            rx_overflow <= rx_overflow | ovfl_pulse;
    end

endmodule

// ==== hw/reg_read_mux.sv ====
// status word, host service-request capture and cpu parallel-port mux
// par is combinational and valid in the same cycle as rd_reg
// counter lanes assume 32-bit counters, four byte lanes
`timescale 1ns/100ps
`include "sdr_config.svh"

module reg_read_mux (
    input  logic                      cpu_clk,
    input  logic                      rx_ovfl_rst,
    reg_bus_if.slave                  bus,
    input  logic                      rx_overflow,
    input  logic                      ctr_ena,
    input  logic [`SDR_CTR_WIDTH-1:0] cpu_ctr0,
    input  logic [`SDR_CTR_WIDTH-1:0] cpu_ctr1,
    input  logic                      host_srq,
    input  sdr_bus_pkg::par_t         host_dout,
    output sdr_bus_pkg::par_t         par,
    output logic                      ser
);
    import sdr_bus_pkg::*;
    import sdr_status_pkg::*;

    status_t status;
    logic    srq_rd;
    logic    srq_noted;  // requests seen since the last GET_SRQ
    logic    srq_out;    // value handed to the cpu serial input

    ////////////////////////////////////////
    // status word
    ////////////////////////////////////////

    assign status.rx_overflow = rx_overflow;
    assign status.rsvd        = 3'b000;
    assign status.fpga_ver    = `SDR_FPGA_VER;
    // user nibble, only the gated counter enable is live
    assign status.user        = {3'b000, ctr_ena};
    assign status.fpga_id     = `SDR_FPGA_ID;

    ////////////////////////////////////////
    // parallel-port read mux
    ////////////////////////////////////////

    // lane n of ctr1 goes high, lane n of ctr0 goes low
    always_comb
    begin
        if (bus.rd_reg && bus.op[OP_GET_CPU_CTR0])
            par = {cpu_ctr1[7:0], cpu_ctr0[7:0]};
        else if (bus.rd_reg && bus.op[OP_GET_CPU_CTR1])
            par = {cpu_ctr1[15:8], cpu_ctr0[15:8]};
        else if (bus.rd_reg && bus.op[OP_GET_CPU_CTR2])
            par = {cpu_ctr1[23:16], cpu_ctr0[23:16]};
        else if (bus.rd_reg && bus.op[OP_GET_CPU_CTR3])
            par = {cpu_ctr1[31:24], cpu_ctr0[31:24]};
        else if (bus.rd_reg && bus.op[OP_GET_STATUS])
            par = status;
        else
            par = host_dout;  // default path, host data
    end

    ////////////////////////////////////////
    // host service request
    ////////////////////////////////////////

    assign srq_rd = bus.rd_reg && bus.op[OP_GET_SRQ];

    // a read hands over what was noted and restarts noting with the current request
    always_ff @(posedge cpu_clk)
    begin
        if (rx_ovfl_rst)
        begin
            srq_noted <= 1'b0;
            srq_out   <= 1'b0;
        end
        else if (srq_rd)
        begin
            srq_noted <= host_srq;
            srq_out   <= srq_noted;
        end
        else
            srq_noted <= srq_noted | host_srq;
    end

    assign ser = srq_out;

endmodule

// ==== hw/sdr_ctrl_top.sv ====
// control and status block of the sdr front end, single cpu_clk domain
// adc overflow flags arrive as a sample stream that cannot be stalled
// register reads are combinational, writes and events land on the next edge
`timescale 1ns/100ps
`include "sdr_config.svh"

module sdr_ctrl_top (
    input  logic                   cpu_clk,
    input  logic                   rx_ovfl_rst,
    input  sdr_bus_pkg::op_t       op,
    input  sdr_bus_pkg::bus_word_t tos,
    input  logic                   rd_reg,
    input  logic                   wr_reg,
    input  logic                   wr_evt,
    input  logic                   adc_valid,
    input  logic                   adc_ovfl,
    input  logic                   host_srq,
    input  sdr_bus_pkg::par_t      host_dout,
    output sdr_bus_pkg::par_t      par,
    output logic                   ser,
    output logic                   osc_en,
    output logic                   eeprom_wp,
    output logic                   interrupt,
    output logic                   rx_overflow
);
    import sdr_status_pkg::*;

    ctrl_t                     ctrl;
    logic [`SDR_CTR_WIDTH-1:0] cpu_ctr0;
    logic [`SDR_CTR_WIDTH-1:0] cpu_ctr1;
    logic                      ctr_ena;
    logic                      ovfl_pulse;

    ////////////////////////////////////////
    // register bus from the pins
    ////////////////////////////////////////

    reg_bus_if u_bus ();

    assign u_bus.op     = op;
    assign u_bus.tos    = tos;
    assign u_bus.rd_reg = rd_reg;
    assign u_bus.wr_reg = wr_reg;
    assign u_bus.wr_evt = wr_evt;

    ctrl_regs u_ctrl_regs (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .bus         (u_bus),
        .ctrl        (ctrl),
        .cpu_ctr0    (cpu_ctr0),
        .cpu_ctr1    (cpu_ctr1),
        .ctr_ena     (ctr_ena)
    );

    adc_ovfl_detect u_adc_ovfl_detect (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .adc_valid   (adc_valid),
        .adc_ovfl    (adc_ovfl),
        .ovfl_pulse  (ovfl_pulse),
        .rx_overflow (rx_overflow)
    );

    reg_read_mux u_reg_read_mux (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .bus         (u_bus),
        .rx_overflow (rx_overflow),
        .ctr_ena     (ctr_ena),
        .cpu_ctr0    (cpu_ctr0),
        .cpu_ctr1    (cpu_ctr1),
        .host_srq    (host_srq),
        .host_dout   (host_dout),
        .par         (par),
        .ser         (ser)
    );

    // control fields out to the board pins
    assign osc_en    = ctrl.osc_en;
    assign eeprom_wp = ctrl.eeprom_wp;
    assign interrupt = ctrl.interrupt;

endmodule

// ==== bench/sdr_ctrl_chk.sv ====
// concurrent checks on the sdr control block, bound into the top level
// all properties sample on the rising edge of cpu_clk
// counter checks assume no clear and no reset in the sampled cycle
`timescale 1ns/100ps
`include "sdr_config.svh"

module sdr_ctrl_chk (
    input logic                   cpu_clk,
    input logic                   rx_ovfl_rst,
    input sdr_bus_pkg::op_t       op,
    input sdr_bus_pkg::bus_word_t tos,
    input logic                   rd_reg,
    input logic                   wr_reg,
    input logic                   wr_evt,
    input sdr_bus_pkg::par_t      host_dout,
    input sdr_bus_pkg::par_t      par,
    input logic                   ser,
    input logic                   osc_en,
    input logic                   eeprom_wp,
    input logic                   interrupt,
    input logic                   rx_overflow,
    input logic                   ovfl_pulse,
    input logic [31:0]            cpu_ctr0,
    input logic [31:0]            cpu_ctr1,
    input logic                   ctr_ena
);
    import sdr_bus_pkg::*;

    int unsigned fail_cnt = 0;
    logic        ctr_clr;
    logic        lane_sel;
    logic [15:0] status_exp;

    assign ctr_clr    = wr_evt && op[OP_CPU_CTR_CLR];
    assign lane_sel   = |op[OP_GET_CPU_CTR3:OP_GET_CPU_CTR0];
    // bit 15 overflow, 11..8 version, bit 4 counter enable, 3..0 id
    assign status_exp = {rx_overflow, 3'b000, `SDR_FPGA_VER, 3'b000, ctr_ena, `SDR_FPGA_ID};

    ////////////////////////////////////////
    // register bus
    ////////////////////////////////////////

    ctrl_write_a: assert property (@(posedge cpu_clk)
        wr_reg && op[OP_SET_CTRL] && !rx_ovfl_rst
        |=> {interrupt, eeprom_wp, osc_en} == $past(tos[2:0]))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("control pins do not follow the written word");
    end

    status_read_a: assert property (@(posedge cpu_clk)
        rd_reg && op[OP_GET_STATUS] && !lane_sel |-> par == status_exp)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("status word on par has the wrong layout");
    end

    // without a read strobe the port shows host data
    host_path_a: assert property (@(posedge cpu_clk) !rd_reg |-> par == host_dout)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("par does not show host data while idle");
    end

    ////////////////////////////////////////
    // cycle counters
    ////////////////////////////////////////

    ctr0_run_a: assert property (@(posedge cpu_clk)
        !rx_ovfl_rst && !ctr_clr |=> cpu_ctr0 == $past(cpu_ctr0) + 32'd1)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("free-running counter skipped or stalled");
    end

    ctr1_hold_a: assert property (@(posedge cpu_clk)
        !rx_ovfl_rst && !ctr_clr && !ctr_ena |=> cpu_ctr1 == $past(cpu_ctr1))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("gated counter moved while disabled");
    end

    ctr_clear_a: assert property (@(posedge cpu_clk)
        !rx_ovfl_rst && ctr_clr |=> cpu_ctr0 == 32'd0 && cpu_ctr1 == 32'd0)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("counter clear event did not zero both counters");
    end

    ////////////////////////////////////////
    // overflow latch and reset
    ////////////////////////////////////////

    pulse_width_a: assert property (@(posedge cpu_clk) ovfl_pulse |=> !ovfl_pulse)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("overflow pulse lasted more than one cycle");
    end

    latch_set_a: assert property (@(posedge cpu_clk)
        !rx_ovfl_rst && (ovfl_pulse || rx_overflow) |=> rx_overflow)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("sticky overflow flag did not set or did not hold");
    end

    reset_a: assert property (@(posedge cpu_clk)
        rx_ovfl_rst |=> !osc_en && !eeprom_wp && !interrupt && !ser && !ctr_ena
        && cpu_ctr0 == 32'd0 && rx_overflow == $past(ovfl_pulse))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("state after reset is not cleared");
    end

endmodule

bind sdr_ctrl_top sdr_ctrl_chk u_sdr_ctrl_chk (
    .cpu_clk     (cpu_clk),
    .rx_ovfl_rst (rx_ovfl_rst),
    .op          (op),
    .tos         (tos),
    .rd_reg      (rd_reg),
    .wr_reg      (wr_reg),
    .wr_evt      (wr_evt),
    .host_dout   (host_dout),
    .par         (par),
    .ser         (ser),
    .osc_en      (osc_en),
    .eeprom_wp   (eeprom_wp),
    .interrupt   (interrupt),
    .rx_overflow (rx_overflow),
    .ovfl_pulse  (ovfl_pulse),
    .cpu_ctr0    (cpu_ctr0),
    .cpu_ctr1    (cpu_ctr1),
    .ctr_ena     (ctr_ena)
);

// ==== bench/tb_clk_gen.sv ====
// cpu_clk source for the testbench, 100 ns period
// por_rst is high from time zero through the fourth rising edge
`timescale 1ns/100ps

module tb_clk_gen (
    output logic cpu_clk,
    output logic por_rst
);
    initial
    begin
        cpu_clk = 1'b0;
        forever
            #50 cpu_clk = ~cpu_clk;
    end

    // non-blocking release, so the fourth edge still samples reset high
    initial
    begin
        por_rst = 1'b1;
        repeat (4) @(posedge cpu_clk);
        por_rst <= 1'b0;
    end

endmodule

// ==== bench/tb_sdr_ctrl.sv ====
// testbench for the sdr control block
// inputs change on the rising edge, outputs are sampled on the falling edge
// the bound checker holds the protocol properties, value checks are counted here
`timescale 1ns/100ps
`include "sdr_config.svh"

module tb_sdr_ctrl;
    import sdr_bus_pkg::*;

    localparam int unsigned MAX_CYCLES = 3000;
    localparam int unsigned WIN        = 1 << `SDR_OVFL_WIN_BITS;

    logic        cpu_clk;
    logic        por_rst;
    logic        rst_req;
    logic        rx_ovfl_rst;
    op_t         op;
    bus_word_t   tos;
    logic        rd_reg;
    logic        wr_reg;
    logic        wr_evt;
    logic        adc_valid;
    logic        adc_ovfl;
    logic        host_srq;
    par_t        host_dout;
    par_t        par;
    logic        ser;
    logic        osc_en;
    logic        eeprom_wp;
    logic        interrupt;
    logic        rx_overflow;
    int unsigned err_cnt;
    int unsigned chk_cnt;
    int unsigned cycle_cnt = 0;
    logic        exp_ovfl;
    logic        exp_ena;

    // power-on reset from the clock source, plus reset pulses from the tests
    assign rx_ovfl_rst = por_rst | rst_req;

    tb_clk_gen u_tb_clk_gen (
        .cpu_clk (cpu_clk),
        .por_rst (por_rst)
    );

    sdr_ctrl_top u_sdr_ctrl_top (
        .cpu_clk     (cpu_clk),
        .rx_ovfl_rst (rx_ovfl_rst),
        .op          (op),
        .tos         (tos),
        .rd_reg      (rd_reg),
        .wr_reg      (wr_reg),
        .wr_evt      (wr_evt),
        .adc_valid   (adc_valid),
        .adc_ovfl    (adc_ovfl),
        .host_srq    (host_srq),
        .host_dout   (host_dout),
        .par         (par),
        .ser         (ser),
        .osc_en      (osc_en),
        .eeprom_wp   (eeprom_wp),
        .interrupt   (interrupt),
        .rx_overflow (rx_overflow)
    );

    ////////////////////////////////////////
    // cycle counter and timeout
    ////////////////////////////////////////

    always @(posedge cpu_clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES)
        begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // status layout: overflow, three zeros, version, three zeros, enable, id
    function automatic par_t expected_status(logic ovfl, logic ena);
        return {ovfl, 3'b000, `SDR_FPGA_VER, 3'b000, ena, `SDR_FPGA_ID};
    endfunction

    task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
        chk_cnt++;
        if (exp !== act)
        begin
            err_cnt++;
            $display("error %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic idle_cycles(int unsigned n);
        repeat (n) @(posedge cpu_clk);
    endtask

    // one-cycle write or event strobe on a single opcode bit
    task automatic bus_write(int unsigned bit_pos, bus_word_t data, bit is_evt);
        @(posedge cpu_clk);
        op     <= 16'h1 << bit_pos;
        tos    <= data;
        wr_reg <= !is_evt;
        wr_evt <= is_evt;
        @(posedge cpu_clk);
        op     <= '0;
        wr_reg <= 1'b0;
        wr_evt <= 1'b0;
    endtask

    // par sampled mid-cycle, with the cycle number of the sample
    task automatic bus_read(int unsigned bit_pos, output par_t val, output int unsigned when);
        @(posedge cpu_clk);
        op     <= 16'h1 << bit_pos;
        rd_reg <= 1'b1;
        @(negedge cpu_clk);
        val  = par;
        when = cycle_cnt;
        @(posedge cpu_clk);
        op     <= '0;
        rd_reg <= 1'b0;
    endtask

    // one window with exactly n_ovfl flags at shuffled positions
    task automatic send_window(int unsigned n_ovfl, bit with_gaps);
        logic [WIN-1:0] flags;
        logic           tmp;
        int unsigned    i;
        int unsigned    j;
        flags = '0;
        for (i = 0; i < n_ovfl; i++)
            flags[i] = 1'b1;
        for (i = WIN - 1; i > 0; i--)
        begin
            j        = $urandom % (i + 1);
            tmp      = flags[i];
            flags[i] = flags[j];
            flags[j] = tmp;
        end
        for (i = 0; i < WIN; i++)
        begin
            // gap cycles carry the overflow bit, which must not count
            if (with_gaps && ($urandom % 4 == 0))
            begin
                @(posedge cpu_clk);
                adc_valid <= 1'b0;
                adc_ovfl  <= 1'b1;
            end
            @(posedge cpu_clk);
            adc_valid <= 1'b1;
            adc_ovfl  <= flags[i];
        end
        @(posedge cpu_clk);
        adc_valid <= 1'b0;
        adc_ovfl  <= 1'b0;
        if (n_ovfl >= WIN / 4)
            exp_ovfl = 1'b1;
    endtask

    // pulse one cycle, then the latch one edge later
    task automatic check_overflow(string name);
        idle_cycles(2);
        @(negedge cpu_clk);
        compare(name, exp_ovfl, rx_overflow);
    endtask

    task automatic pulse_reset();
        @(posedge cpu_clk);
        rst_req <= 1'b1;
        @(posedge cpu_clk);
        rst_req <= 1'b0;
        exp_ovfl = 1'b0;
        exp_ena  = 1'b0;
        @(negedge cpu_clk);
        compare("ovfl_reset", exp_ovfl, rx_overflow);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial
    begin
        par_t        rd_val;
        par_t        rd_prev;
        int unsigned t_now;
        int unsigned t_prev;
        bus_word_t   wdata;
        logic [7:0]  lane_exp;
        int unsigned asrt_cnt;
        void'($urandom(2006));
        op        = '0;
        tos       = '0;
        rd_reg    = 1'b0;
        wr_reg    = 1'b0;
        wr_evt    = 1'b0;
        adc_valid = 1'b0;
        adc_ovfl  = 1'b0;
        host_srq  = 1'b0;
        host_dout = '0;
        rst_req   = 1'b0;
        err_cnt   = 0;
        chk_cnt   = 0;
        exp_ovfl  = 1'b0;
        exp_ena   = 1'b0;
        @(negedge por_rst);

        // control write, pins follow tos bits 2..0
        repeat (4)
        begin
            wdata = $urandom;
            bus_write(OP_SET_CTRL, wdata, 1'b0);
            @(negedge cpu_clk);
            compare("ctrl_write", wdata[2:0], {interrupt, eeprom_wp, osc_en});
        end

        // status read and the default host path
        bus_read(OP_GET_STATUS, rd_val, t_now);
        compare("status_idle", expected_status(exp_ovfl, exp_ena), rd_val);
        wdata = $urandom;
        @(posedge cpu_clk);
        host_dout <= wdata[15:0];
        @(negedge cpu_clk);
        compare("host_dout", wdata[15:0], par);

        // overflow windows around the quarter threshold
        send_window(10, 1'b1);
        check_overflow("ovfl_10");
        send_window(15, 1'b1);
        check_overflow("ovfl_15");
        send_window(16, 1'b1);
        check_overflow("ovfl_16");
        bus_read(OP_GET_STATUS, rd_val, t_now);
        compare("status_ovfl", expected_status(exp_ovfl, exp_ena), rd_val);
        pulse_reset();
        send_window(16 + $urandom % 48, 1'b0);
        check_overflow("ovfl_rand");

        // counters after clear and enable
        // run the gated counter first so the clear has a count to zero
        bus_write(OP_CPU_CTR_ENA, '0, 1'b1);
        bus_write(OP_CPU_CTR_CLR, '0, 1'b1);
        bus_write(OP_CPU_CTR_ENA, '0, 1'b1);
        exp_ena = 1'b1;
        bus_read(OP_GET_STATUS, rd_val, t_now);
        compare("status_ena", expected_status(exp_ovfl, exp_ena), rd_val);
        bus_read(OP_GET_CPU_CTR0, rd_prev, t_prev);
        idle_cycles(5 + $urandom % 40);
        bus_read(OP_GET_CPU_CTR0, rd_val, t_now);
        lane_exp = rd_prev[7:0] + 8'(t_now - t_prev);
        compare("ctr0_lane0", lane_exp, rd_val[7:0]);
        lane_exp = rd_prev[15:8] + 8'(t_now - t_prev);
        compare("ctr1_lane0", lane_exp, rd_val[15:8]);

        // gated counter frozen after disable
        bus_write(OP_CPU_CTR_DIS, '0, 1'b1);
        exp_ena = 1'b0;
        bus_read(OP_GET_CPU_CTR0, rd_prev, t_prev);
        idle_cycles(5 + $urandom % 40);
        bus_read(OP_GET_CPU_CTR0, rd_val, t_now);
        lane_exp = rd_prev[7:0] + 8'(t_now - t_prev);
        compare("ctr0_after_dis", lane_exp, rd_val[7:0]);
        compare("ctr1_held", rd_prev[15:8], rd_val[15:8]);
        // well under 256 cycles since the clear
        bus_read(OP_GET_CPU_CTR3, rd_val, t_now);
        compare("ctr_lane3", 16'h0000, rd_val);

        // service request reaches ser on the next read, then clears
        bus_read(OP_GET_SRQ, rd_val, t_now);
        @(posedge cpu_clk);
        host_srq <= 1'b1;
        @(posedge cpu_clk);
        host_srq <= 1'b0;
        bus_read(OP_GET_SRQ, rd_val, t_now);
        @(negedge cpu_clk);
        compare("srq_set", 1'b1, ser);
        bus_read(OP_GET_SRQ, rd_val, t_now);
        @(negedge cpu_clk);
        compare("srq_clear", 1'b0, ser);

        // reset with the gated counter running and the overflow flag set
        bus_write(OP_CPU_CTR_ENA, '0, 1'b1);
        pulse_reset();

        idle_cycles(4);
        @(negedge cpu_clk);
        asrt_cnt = u_sdr_ctrl_top.u_sdr_ctrl_chk.fail_cnt;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 chk_cnt, err_cnt, asrt_cnt);
        if (err_cnt == 0 && asrt_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
hw/sdr_bus_pkg.sv
hw/sdr_status_pkg.sv
hw/reg_bus_if.sv
hw/ctrl_regs.sv
hw/adc_ovfl_detect.sv
hw/reg_read_mux.sv
hw/sdr_ctrl_top.sv
bench/sdr_ctrl_chk.sv
bench/tb_clk_gen.sv
bench/tb_sdr_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
# the error limit lets failed assertions reach the closing report
verilator --binary --timing --assert -Wno-fatal --top-module tb_sdr_ctrl \
    -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -x "Test passed" > /dev/null \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }
